// File: verilog/camera_pkg.sv
// types and constants for the camera-side pixel path
package camera_pkg;

  typedef logic [7:0]  byte_t;    // camera bus byte or 8-bit colour channel
  typedef logic [15:0] rgb565_t;  // r[15:11] g[10:5] b[4:0]
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;
  typedef logic [23:0] ycrcb_t;   // {y, cr, cb}

  // counts saturate one below these
  localparam hcount_t frame_width  = 11'd1280;
  localparam vcount_t frame_height = 10'd720;

  // bt.601 style weights, scaled by 256
  localparam int coef_y_r  = 66;
  localparam int coef_y_g  = 129;
  localparam int coef_y_b  = 25;
  localparam int coef_cb_r = -38;
  localparam int coef_cb_g = -74;
  localparam int coef_cb_b = 112;
  localparam int coef_cr_r = 112;
  localparam int coef_cr_g = -94;
  localparam int coef_cr_b = -18;

  localparam int luma_offset   = 16;   // y sits in 16..235
  localparam int chroma_offset = 128;  // cr/cb centred on 128
  localparam int round_bias    = 128;  // half lsb before the >>> 8

endpackage

// File: verilog/mask_regs_pkg.sv
// register map of the threshold bank on the wishbone side
package mask_regs_pkg;

  localparam int wb_addr_w = 3;  // word address, 8 slots
  localparam int wb_data_w = 8;  // one bound per word

  typedef logic [wb_addr_w-1:0] wb_addr_t;
  typedef logic [wb_data_w-1:0] wb_data_t;

  // lower and upper bound per channel, 6 and 7 unused
  localparam wb_addr_t addr_y_lo  = 3'd0;
  localparam wb_addr_t addr_y_hi  = 3'd1;
  localparam wb_addr_t addr_cr_lo = 3'd2;
  localparam wb_addr_t addr_cr_hi = 3'd3;
  localparam wb_addr_t addr_cb_lo = 3'd4;
  localparam wb_addr_t addr_cb_hi = 3'd5;

  // widest window, every pixel passes out of reset
  localparam wb_data_t bound_lo_reset = 8'd0;
  localparam wb_data_t bound_hi_reset = 8'd255;

endpackage

// File: verilog/pixel_stream_if.sv
`timescale 1ns/1ps

// one pixel per valid cycle, no ready, coordinates ride along with the data
interface pixel_stream_if #(
  parameter int data_w = 16  // 16 for rgb565, 24 for ycrcb
);
  import camera_pkg::*;

  logic              valid;
  hcount_t           hcount;
  vcount_t           vcount;
  logic [data_w-1:0] data;

  modport sender (
    output valid,
    output hcount,
    output vcount,
    output data
  );

  modport receiver (
    input valid,
    input hcount,
    input vcount,
    input data
  );

endinterface

// File: verilog/bounds_if.sv
`timescale 1ns/1ps

// inclusive [lo, hi] window for each of y, cr, cb
interface bounds_if;
  import camera_pkg::*;

  byte_t y_lo, y_hi;
  byte_t cr_lo, cr_hi;
  byte_t cb_lo, cb_hi;

  modport owner (output y_lo, y_hi, cr_lo, cr_hi, cb_lo, cb_hi);  // register bank
  modport user  (input  y_lo, y_hi, cr_lo, cr_hi, cb_lo, cb_hi);  // comparator

endinterface

// File: verilog/camera_capture.sv
`timescale 1ns/1ps

module camera_capture (
  input  logic              clk_camera,
  input  logic              sys_rst_camera,
  input  camera_pkg::byte_t camera_d_i,
  input  logic              cam_pclk_i,
  input  logic              cam_hsync_i,
  input  logic              cam_vsync_i,
  pixel_stream_if.sender    px_o
);
  import camera_pkg::*;

  byte_t   d_s1, d_s2;
  logic    pclk_s1, pclk_s2, pclk_prev;
  logic    hs_s1, hs_s2, hs_prev;
  logic    vs_s1, vs_s2, vs_prev;
  logic    byte_v_a, hs_a, hs_fall_a, vs_rise_a;  // stage a: edge detect
  byte_t   byte_a;
  logic    phase_b, pix_v_b, hs_fall_b, vs_rise_b;  // stage b: byte pairing
  byte_t   hi_b;
  rgb565_t pix_b;
  hcount_t h_cnt;  // count the next pixel will carry
  vcount_t v_cnt;
  logic    line_has_px;

  // two-flop synchronisers, data needs no reset
  always_ff @(posedge clk_camera) begin
    d_s1 <= camera_d_i;
    d_s2 <= d_s1;
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      pclk_s1   <= 1'b0;
      pclk_s2   <= 1'b0;
      pclk_prev <= 1'b0;
      hs_s1     <= 1'b0;
      hs_s2     <= 1'b0;
      hs_prev   <= 1'b0;
      vs_s1     <= 1'b0;
      vs_s2     <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      pclk_s1   <= cam_pclk_i;
      pclk_s2   <= pclk_s1;
      pclk_prev <= pclk_s2;  // one more tap for edge detect
      hs_s1     <= cam_hsync_i;
      hs_s2     <= hs_s1;
      hs_prev   <= hs_s2;
      vs_s1     <= cam_vsync_i;
      vs_s2     <= vs_s1;
      vs_prev   <= vs_s2;
    end
  end

  // stage a: register the edges, a byte counts only inside hsync
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      byte_v_a  <= 1'b0;
      hs_a      <= 1'b0;
      hs_fall_a <= 1'b0;
      vs_rise_a <= 1'b0;
    end else begin
      byte_v_a  <= pclk_s2 & ~pclk_prev & hs_s2;
      hs_a      <= hs_s2;
      hs_fall_a <= hs_prev & ~hs_s2;  // end of line
      vs_rise_a <= vs_s2 & ~vs_prev;  // start of frame
    end
  end

  always_ff @(posedge clk_camera) begin
    byte_a <= d_s2;  // lines up with byte_v_a
  end

  // stage b: first byte is the high half, second completes the pixel
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      phase_b   <= 1'b0;
      pix_v_b   <= 1'b0;
      hs_fall_b <= 1'b0;
      vs_rise_b <= 1'b0;
    end else begin
      pix_v_b   <= 1'b0;
      hs_fall_b <= hs_fall_a;
      vs_rise_b <= vs_rise_a;
      if (!hs_a) begin
        phase_b <= 1'b0;  // realign at every blanking
      end else if (byte_v_a) begin
        phase_b <= ~phase_b;
        pix_v_b <= phase_b;  // second byte in
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (byte_v_a) begin
      if (!phase_b) hi_b <= byte_a;
      else          pix_b <= {hi_b, byte_a};
    end
  end

  // stage c: stamp coordinates and launch the pixel
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      px_o.valid  <= 1'b0;
      h_cnt       <= '0;
      v_cnt       <= '0;
      line_has_px <= 1'b0;
    end else begin
      px_o.valid <= pix_v_b;
      if (vs_rise_b) begin
        h_cnt       <= '0;
        v_cnt       <= '0;
        line_has_px <= 1'b0;
      end else if (hs_fall_b) begin
        h_cnt       <= '0;
        line_has_px <= 1'b0;
        // empty lines do not advance the row
        if (line_has_px && v_cnt != frame_height - 1'b1) v_cnt <= v_cnt + 1'b1;
      end else if (pix_v_b) begin
        line_has_px <= 1'b1;
        if (h_cnt != frame_width - 1'b1) h_cnt <= h_cnt + 1'b1;  // saturate
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (pix_v_b) begin
      px_o.data   <= pix_b;
      px_o.hcount <= h_cnt;
      px_o.vcount <= v_cnt;
    end
  end

endmodule

// File: verilog/color_convert.sv
`timescale 1ns/1ps

module color_convert (
  input  logic             clk_camera,
  input  logic             sys_rst_camera,
  pixel_stream_if.receiver px_i,   // rgb565
  pixel_stream_if.sender   ycc_o   // ycrcb
);
  import camera_pkg::*;

  byte_t              r1, g1, b1;
  logic               v1, v2;
  hcount_t            h1, h2;
  vcount_t            vc1, vc2;
  logic signed [17:0] y_sum, cr_sum, cb_sum;  // worst case 56100 or -28560

  // round, drop the x256 weight scale, re-centre
  function automatic byte_t scale(input logic signed [17:0] sum, input int offset);
    int t;
    t = ((int'(sum) + round_bias) >>> 8) + offset;
    return byte_t'(t);  // always lands in 16..240
  endfunction

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      v1          <= 1'b0;
      v2          <= 1'b0;
      ycc_o.valid <= 1'b0;
    end else begin
      v1          <= px_i.valid;
      v2          <= v1;
      ycc_o.valid <= v2;
    end
  end

  // stage 1: 565 to 888, low bits zero filled
  always_ff @(posedge clk_camera) begin
    r1  <= {px_i.data[15:11], 3'b0};
    g1  <= {px_i.data[10:5], 2'b0};
    b1  <= {px_i.data[4:0], 3'b0};
    h1  <= px_i.hcount;
    vc1 <= px_i.vcount;
  end

  // stage 2: weighted sums, channels widened to signed
  always_ff @(posedge clk_camera) begin
    y_sum  <= 18'(coef_y_r * $signed({1'b0, r1}) + coef_y_g * $signed({1'b0, g1})
                + coef_y_b * $signed({1'b0, b1}));
    cr_sum <= 18'(coef_cr_r * $signed({1'b0, r1}) + coef_cr_g * $signed({1'b0, g1})
                + coef_cr_b * $signed({1'b0, b1}));
    cb_sum <= 18'(coef_cb_r * $signed({1'b0, r1}) + coef_cb_g * $signed({1'b0, g1})
                + coef_cb_b * $signed({1'b0, b1}));
    h2     <= h1;
    vc2    <= vc1;
  end

  // stage 3: pack as {y, cr, cb}
  always_ff @(posedge clk_camera) begin
    ycc_o.data   <= {scale(y_sum, luma_offset), scale(cr_sum, chroma_offset),
                     scale(cb_sum, chroma_offset)};
    ycc_o.hcount <= h2;
    ycc_o.vcount <= vc2;
  end

endmodule

// File: verilog/threshold_mask.sv
`timescale 1ns/1ps

module threshold_mask (
  input  logic                clk_camera,
  input  logic                sys_rst_camera,
  pixel_stream_if.receiver    ycc_i,
  bounds_if.user              bounds_i,
  output logic                mask_valid_o,
  output logic                mask_o,
  output camera_pkg::hcount_t mask_hcount_o,
  output camera_pkg::vcount_t mask_vcount_o
);
  import camera_pkg::*;

  ycrcb_t pix;
  byte_t  y, cr, cb;
  logic   in_window;

  assign pix = ycc_i.data;
  assign y   = pix[23:16];
  assign cr  = pix[15:8];
  assign cb  = pix[7:0];

  // inclusive at both ends, all three channels must pass
  assign in_window = (y  >= bounds_i.y_lo)  && (y  <= bounds_i.y_hi)
                  && (cr >= bounds_i.cr_lo) && (cr <= bounds_i.cr_hi)
                  && (cb >= bounds_i.cb_lo) && (cb <= bounds_i.cb_hi);

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) mask_valid_o <= 1'b0;
    else                mask_valid_o <= ycc_i.valid;
  end

  always_ff @(posedge clk_camera) begin
    mask_o        <= in_window;
    mask_hcount_o <= ycc_i.hcount;  // coordinates follow the bit
    mask_vcount_o <= ycc_i.vcount;
  end

endmodule

// File: verilog/threshold_regs.sv
`timescale 1ns/1ps

module threshold_regs (
  input  logic                    clk_camera,
  input  logic                    sys_rst_camera,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  mask_regs_pkg::wb_addr_t wb_adr_i,
  input  mask_regs_pkg::wb_data_t wb_dat_i,
  output mask_regs_pkg::wb_data_t wb_dat_o,
  output logic                    wb_ack_o,
  bounds_if.owner                 bounds_o
);
  import mask_regs_pkg::*;

  wb_data_t y_lo_q, y_hi_q, cr_lo_q, cr_hi_q, cb_lo_q, cb_hi_q;
  wb_data_t rd_mux;
  logic     req;

  // a new request only while ack is low, so one strobe gives one ack
  assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_comb begin
    case (wb_adr_i)
      addr_y_lo:  rd_mux = y_lo_q;
      addr_y_hi:  rd_mux = y_hi_q;
      addr_cr_lo: rd_mux = cr_lo_q;
      addr_cr_hi: rd_mux = cr_hi_q;
      addr_cb_lo: rd_mux = cb_lo_q;
      addr_cb_hi: rd_mux = cb_hi_q;
      default:    rd_mux = '0;  // 6 and 7 read zero
    endcase
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      wb_ack_o <= 1'b0;
      y_lo_q   <= bound_lo_reset;
      y_hi_q   <= bound_hi_reset;
      cr_lo_q  <= bound_lo_reset;
      cr_hi_q  <= bound_hi_reset;
      cb_lo_q  <= bound_lo_reset;
      cb_hi_q  <= bound_hi_reset;
    end else begin
      wb_ack_o <= req;  // single cycle ack, one clock after cyc & stb
      if (req && wb_we_i) begin  // lands together with ack
        case (wb_adr_i)
          addr_y_lo:  y_lo_q  <= wb_dat_i;
          addr_y_hi:  y_hi_q  <= wb_dat_i;
          addr_cr_lo: cr_lo_q <= wb_dat_i;
          addr_cr_hi: cr_hi_q <= wb_dat_i;
          addr_cb_lo: cb_lo_q <= wb_dat_i;
          addr_cb_hi: cb_hi_q <= wb_dat_i;
          default: ;  // unmapped, write dropped
        endcase
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (req) wb_dat_o <= rd_mux;  // valid with ack
  end

  assign bounds_o.y_lo  = y_lo_q;
  assign bounds_o.y_hi  = y_hi_q;
  assign bounds_o.cr_lo = cr_lo_q;
  assign bounds_o.cr_hi = cr_hi_q;
  assign bounds_o.cb_lo = cb_lo_q;
  assign bounds_o.cb_hi = cb_hi_q;

endmodule

// File: verilog/mask_pipeline_top.sv
`timescale 1ns/1ps

module mask_pipeline_top (
  input  logic                    clk_camera,
  input  logic                    sys_rst_camera,
  // camera bus, asynchronous to clk_camera
  input  camera_pkg::byte_t       camera_d_i,
  input  logic                    cam_pclk_i,
  input  logic                    cam_hsync_i,
  input  logic                    cam_vsync_i,
  // wishbone classic slave for the bounds
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  mask_regs_pkg::wb_addr_t wb_adr_i,
  input  mask_regs_pkg::wb_data_t wb_dat_i,
  output mask_regs_pkg::wb_data_t wb_dat_o,
  output logic                    wb_ack_o,
  // mask stream, 8 clocks behind the pclk edge at the pin
  output logic                    mask_valid_o,
  output logic                    mask_o,
  output camera_pkg::hcount_t     mask_hcount_o,
  output camera_pkg::vcount_t     mask_vcount_o
);
  import camera_pkg::*;

  pixel_stream_if #(.data_w($bits(rgb565_t))) raw_px ();
  pixel_stream_if #(.data_w($bits(ycrcb_t)))  ycc_px ();
  bounds_if                                   bounds ();

  camera_capture u_capture (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .camera_d_i     (camera_d_i),
    .cam_pclk_i     (cam_pclk_i),
    .cam_hsync_i    (cam_hsync_i),
    .cam_vsync_i    (cam_vsync_i),
    .px_o           (raw_px.sender)
  );

  color_convert u_convert (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .px_i           (raw_px.receiver),
    .ycc_o          (ycc_px.sender)
  );

  threshold_mask u_mask (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .ycc_i          (ycc_px.receiver),
    .bounds_i       (bounds.user),
    .mask_valid_o   (mask_valid_o),
    .mask_o         (mask_o),
    .mask_hcount_o  (mask_hcount_o),
    .mask_vcount_o  (mask_vcount_o)
  );

  threshold_regs u_regs (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .bounds_o       (bounds.owner)
  );

endmodule

// File: verif/mask_pipeline_properties.sv
`timescale 1ns/1ps

// wishbone handshake and capture stream rules, bound into the design
module mask_pipeline_properties (
  input logic                clk_camera,
  input logic                sys_rst_camera,
  input logic                wb_cyc_i,
  input logic                wb_stb_i,
  input logic                wb_ack_i,
  input logic                px_valid_i,
  input camera_pkg::hcount_t px_hcount_i
);
  import camera_pkg::*;

  // one request gives exactly one ack
  ack_single: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
    wb_ack_i |=> !wb_ack_i)
    else $error("wishbone ack high two cycles in a row");

  ack_after_req: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
    wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))  // ack only answers a strobe
    else $error("wishbone ack without cyc and stb the cycle before");

  // saturating count stays inside the frame
  hcount_range: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
    px_valid_i |-> (px_hcount_i < frame_width))
    else $error("capture hcount reached frame width");

endmodule

bind threshold_regs mask_pipeline_properties u_regs_props (
  .clk_camera     (clk_camera),
  .sys_rst_camera (sys_rst_camera),
  .wb_cyc_i       (wb_cyc_i),
  .wb_stb_i       (wb_stb_i),
  .wb_ack_i       (wb_ack_o),
  .px_valid_i     (1'b0),
  .px_hcount_i    ('0)
);

bind camera_capture mask_pipeline_properties u_capture_props (
  .clk_camera     (clk_camera),
  .sys_rst_camera (sys_rst_camera),
  .wb_cyc_i       (1'b0),
  .wb_stb_i       (1'b0),
  .wb_ack_i       (1'b0),
  .px_valid_i     (px_o.valid),
  .px_hcount_i    (px_o.hcount)
);

// File: verif/mask_pipeline_tb.sv
`timescale 1ns/1ps

module mask_pipeline_tb;
  import camera_pkg::*;
  import mask_regs_pkg::*;

  localparam int n_frames       = 9;
  localparam int max_lines      = 3;
  localparam int line_cycles    = 4 + 16 * 2 * 4 + 8;  // lead-in, 16 pixels, blanking
  localparam int frame_cycles   = 8 + max_lines * line_cycles + 12;
  localparam int n_wb           = 60;  // bus accesses over the whole run
  localparam int timeout_cycles = 2 * (n_frames * frame_cycles + n_wb * 3 + 10);

  logic        clk_camera, sys_rst_camera;
  byte_t       cam_d;
  logic        cam_pclk, cam_hsync, cam_vsync;
  logic        wb_cyc, wb_stb, wb_we, wb_ack;
  wb_addr_t    wb_adr;
  wb_data_t    wb_dat_w, wb_dat_r;
  logic        mask_valid, mask;
  hcount_t     mask_h;
  vcount_t     mask_v;

  logic [31:0] rng_state = 32'h462e84b5;
  wb_data_t    regs_model [0:7];  // 6 and 7 stay zero
  logic [21:0] exp_q [$];         // {mask, hcount, vcount} in send order
  vcount_t     v_model;
  string       test_name;
  int          err_mask, err_coord, err_reg, err_other;
  int          n_sent, n_seen, cycle;

  mask_pipeline_top u_dut (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .camera_d_i     (cam_d),
    .cam_pclk_i     (cam_pclk),
    .cam_hsync_i    (cam_hsync),
    .cam_vsync_i    (cam_vsync),
    .wb_cyc_i       (wb_cyc),
    .wb_stb_i       (wb_stb),
    .wb_we_i        (wb_we),
    .wb_adr_i       (wb_adr),
    .wb_dat_i       (wb_dat_w),
    .wb_dat_o       (wb_dat_r),
    .wb_ack_o       (wb_ack),
    .mask_valid_o   (mask_valid),
    .mask_o         (mask),
    .mask_hcount_o  (mask_h),
    .mask_vcount_o  (mask_v)
  );

  initial begin
    clk_camera = 1'b0;
    forever #50 clk_camera = ~clk_camera;  // 100 ns period
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // reference conversion straight from the 565 expansion and the weights
  function automatic ycrcb_t rgb_to_ycc(input rgb565_t px);
    int r, g, b, y, cr, cb;
    r  = int'(px[15:11]) << 3;  // low bits zero filled
    g  = int'(px[10:5]) << 2;
    b  = int'(px[4:0]) << 3;
    y  = ((coef_y_r * r + coef_y_g * g + coef_y_b * b + round_bias) >>> 8) + luma_offset;
    cr = ((coef_cr_r * r + coef_cr_g * g + coef_cr_b * b + round_bias) >>> 8) + chroma_offset;
    cb = ((coef_cb_r * r + coef_cb_g * g + coef_cb_b * b + round_bias) >>> 8) + chroma_offset;
    return {y[7:0], cr[7:0], cb[7:0]};
  endfunction

  // inclusive window per channel against the bounds written so far
  function automatic logic in_bounds(input ycrcb_t ycc);
    return ycc[23:16] >= regs_model[addr_y_lo] && ycc[23:16] <= regs_model[addr_y_hi]
        && ycc[15:8] >= regs_model[addr_cr_lo] && ycc[15:8] <= regs_model[addr_cr_hi]
        && ycc[7:0] >= regs_model[addr_cb_lo] && ycc[7:0] <= regs_model[addr_cb_hi];
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_camera);
    #1;  // inputs move just after the edge
  endtask

  // one classic cycle, held until ack
  task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t din,
                           output wb_data_t dout);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = din;
    wait_cycles(1);
    while (wb_ack !== 1'b1) wait_cycles(1);
    dout   = wb_dat_r;  // read data comes with ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    wait_cycles(1);
  endtask

  task automatic reg_write(input wb_addr_t adr, input wb_data_t d);
    wb_data_t ignored;
    wb_access(1'b1, adr, d, ignored);
    if (adr < 3'd6) regs_model[adr] = d;  // 6 and 7 drop writes
  endtask

  task automatic reg_check(input wb_addr_t adr);
    wb_data_t rd;
    wb_access(1'b0, adr, 8'h00, rd);
    if (rd !== regs_model[adr]) begin
      $display("Fail %s: reg %0d expected %02h actual %02h", test_name, adr,
               regs_model[adr], rd);
      err_reg++;
    end
  endtask

  task automatic send_byte(input byte_t b);
    cam_pclk = 1'b0;
    cam_d    = b;
    wait_cycles(2);
    cam_pclk = 1'b1;  // rising edge takes the byte
    wait_cycles(2);
  endtask

  task automatic send_line(input int n_px, input logic pick, input rgb565_t colour);
    rgb565_t     px;
    logic [31:0] r;
    cam_hsync = 1'b1;
    wait_cycles(4);
    for (int i = 0; i < n_px; i++) begin
      r  = lcg_next();
      px = (pick && r[31]) ? colour : r[23:8];  // about half the chosen colour
      exp_q.push_back({in_bounds(rgb_to_ycc(px)), hcount_t'(i), v_model});
      n_sent++;
      send_byte(px[15:8]);  // high half first
      send_byte(px[7:0]);
    end
    cam_pclk  = 1'b0;
    cam_hsync = 1'b0;
    wait_cycles(8);
    v_model = v_model + 1'b1;  // every line here has pixels
  endtask

  task automatic send_frame(input logic pick, input rgb565_t colour);
    logic [31:0] r;
    int          n_lines;
    r         = lcg_next();
    n_lines   = 2 + int'(r[20]);
    cam_vsync = 1'b1;
    wait_cycles(4);
    cam_vsync = 1'b0;
    wait_cycles(4);
    v_model = '0;
    for (int l = 0; l < n_lines; l++) begin
      r = lcg_next();
      send_line(1 + int'(r[27:24]), pick, colour);
    end
    wait_cycles(12);  // pipeline empty before the next bound write
  endtask

  task automatic random_bounds();
    logic [31:0] r;
    wb_data_t    lo;
    for (int k = 0; k < 3; k++) begin
      r  = lcg_next();
      lo = {1'b0, r[14:8]};
      reg_write(wb_addr_t'(2 * k), lo);
      reg_write(wb_addr_t'(2 * k + 1), lo + {1'b0, r[22:16]});  // hi never below lo
    end
  endtask

  task automatic check_pixel();
    logic [21:0] e;
    if (exp_q.size() == 0) begin
      $display("mask pixel at (%0d,%0d) came out with no pixel sent for it", mask_h, mask_v);
      err_other++;
    end else begin
      e = exp_q.pop_front();
      n_seen++;
      if (mask !== e[21]) begin
        $display("Fail %s: mask at (%0d,%0d) expected %0b actual %0b", test_name,
                 e[20:10], e[9:0], e[21], mask);
        err_mask++;
      end
      if (mask_h !== e[20:10] || mask_v !== e[9:0]) begin
        $display("Fail %s: coords expected (%0d,%0d) actual (%0d,%0d)", test_name,
                 e[20:10], e[9:0], mask_h, mask_v);
        err_coord++;
      end
    end
  endtask

  always @(negedge clk_camera) begin
    if (mask_valid === 1'b1) check_pixel();  // mid-cycle, outputs settled
  end

  initial begin
    cycle = 0;
    while (cycle < timeout_cycles) begin
      @(posedge clk_camera);
      cycle++;
    end
    $display("timeout: run still going after %0d cycles", timeout_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] r;
    rgb565_t     colour;
    ycrcb_t      ycc;
    sys_rst_camera = 1'b1;
    cam_d          = '0;
    cam_pclk       = 1'b0;
    cam_hsync      = 1'b0;
    cam_vsync      = 1'b0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_dat_w       = '0;
    v_model        = '0;
    err_mask       = 0;
    err_coord      = 0;
    err_reg        = 0;
    err_other      = 0;
    n_sent         = 0;
    n_seen         = 0;
    for (int a = 0; a < 8; a++) regs_model[wb_addr_t'(a)] = (a < 6 && a % 2 == 1) ? 8'd255 : 8'd0;
    repeat (2) @(posedge clk_camera);
    #1;
    sys_rst_camera = 1'b0;
    wait_cycles(2);

    test_name = "reset_values";  // full window, every mask bit 1
    for (int a = 0; a < 8; a++) reg_check(wb_addr_t'(a));
    send_frame(1'b0, '0);

    test_name = "reg_rw";
    for (int a = 0; a < 8; a++) begin
      r = lcg_next();
      reg_write(wb_addr_t'(a), r[15:8]);
    end
    for (int a = 0; a < 8; a++) reg_check(wb_addr_t'(a));

    test_name = "random_bounds";
    repeat (4) begin
      random_bounds();
      send_frame(1'b0, '0);
    end

    test_name = "counts";
    repeat (2) send_frame(1'b0, '0);

    test_name = "one_colour";  // byte order and 565 expansion
    repeat (2) begin
      r      = lcg_next();
      colour = r[27:12];
      ycc    = rgb_to_ycc(colour);
      reg_write(addr_y_lo, ycc[23:16]);
      reg_write(addr_y_hi, ycc[23:16]);
      reg_write(addr_cr_lo, ycc[15:8]);
      reg_write(addr_cr_hi, ycc[15:8]);
      reg_write(addr_cb_lo, ycc[7:0]);
      reg_write(addr_cb_hi, ycc[7:0]);
      send_frame(1'b1, colour);
    end

    wait_cycles(20);
    if (exp_q.size() != 0 || n_seen != n_sent) begin
      $display("pixels lost: sent %0d, mask pixels seen %0d", n_sent, n_seen);
      err_other++;
    end
    $display("errors: mask %0d, coord %0d, reg %0d, other %0d", err_mask, err_coord,
             err_reg, err_other);
    if (err_mask + err_coord + err_reg + err_other == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: camera_mask.f
verilog/camera_pkg.sv
verilog/mask_regs_pkg.sv
verilog/pixel_stream_if.sv
verilog/bounds_if.sv
verilog/camera_capture.sv
verilog/color_convert.sv
verilog/threshold_mask.sv
verilog/threshold_regs.sv
verilog/mask_pipeline_top.sv
verif/mask_pipeline_properties.sv
verif/mask_pipeline_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = mask_pipeline_tb
RTL_TOP   = mask_pipeline_top
FILELIST  = camera_mask.f
LOG       = sim.log
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim: build
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
